//--- src/rv_exec_pkg.sv
/*
 * Shared encodings and stage payloads for the RV64 execute/memory slice.
 * Only integer ALU operations and aligned loads and stores are encoded.
 */
package rv_exec_pkg;

    localparam int xlen = 64;

    // ------------------------------------------------------------------------
    // Operation and operand select encodings
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    typedef enum logic [1:0] {
        src1_rs1,
        src1_pc,
        src1_zero
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_rs2,
        src2_imm,
        src2_four
    } src2_sel_t;

    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w,
        size_d
    } mem_size_t;

    // ------------------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        alu_op_t         alu_op;
        src1_sel_t       src1_sel;
        src2_sel_t       src2_sel;
        logic            word_op;
        logic            rf_we;
        logic            mem_re;
        logic            mem_we;
        mem_size_t       mem_size;
        logic            load_unsigned;
        logic [4:0]      rd;
        logic [11:0]     imm;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] pc;
    } es_payload_t;

    typedef struct packed {
        logic            rf_we;
        logic            mem_re;
        mem_size_t       mem_size;
        logic            load_unsigned;
        logic [2:0]      addr_lo;
        logic [4:0]      rd;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] pc;
    } ms_payload_t;

endpackage

//--- src/pipe_stage.sv
/*
 * One pipeline slot with a valid/allowin handshake.
 * out_valid never depends on out_allowin; the payload has no reset.
 */
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     allowin,
    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_allowin
);

    logic     valid_q;
    payload_t payload_q;

    // Load when empty, or when the held item is leaving
    assign allowin = !valid_q || out_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            payload_q <= in_payload;
        end
    end

    assign out_valid   = valid_q;
    assign out_payload = payload_q;

endmodule

//--- src/alu.sv
/*
 * Integer ALU for RV64. In word mode the low 32 bits of the result are
 * sign-extended and shifts use a 5-bit amount.
 */
`timescale 1ns/1ps

module alu
    import rv_exec_pkg::*;
(
    input  alu_op_t         alu_op,
    input  logic            word_op,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result
);

    logic [5:0]      shamt;
    logic [xlen-1:0] srl_src;
    logic [xlen-1:0] sra_src;
    logic [xlen-1:0] raw;

    // Word shifts only see the low half of src1
    assign shamt   = word_op ? {1'b0, src2[4:0]} : src2[5:0];
    assign srl_src = word_op ? {32'b0, src1[31:0]} : src1;
    assign sra_src = word_op ? {{32{src1[31]}}, src1[31:0]} : src1;

    always_comb begin
        case (alu_op)
            alu_add: begin
                raw = src1 + src2;
            end
            alu_sub: begin
                raw = src1 - src2;
            end
            alu_slt: begin
                raw = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            alu_sltu: begin
                raw = {{(xlen-1){1'b0}}, src1 < src2};
            end
            alu_and: begin
                raw = src1 & src2;
            end
            alu_or: begin
                raw = src1 | src2;
            end
            alu_xor: begin
                raw = src1 ^ src2;
            end
            alu_sll: begin
                raw = src1 << shamt;
            end
            alu_srl: begin
                raw = srl_src >> shamt;
            end
            alu_sra: begin
                raw = $signed(sra_src) >>> shamt;
            end
            default: begin
                raw = '0;
            end
        endcase
    end

    assign result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

//--- src/exu.sv
/*
 * Execute stage: operand select, ALU and data RAM request.
 * Accesses are assumed aligned to their size; no misalignment check.
 * The RAM request fires only when the item moves to the memory stage.
 */
`timescale 1ns/1ps

module exu
    import rv_exec_pkg::*;
#(
    parameter int ram_addr_bits = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    // Decode side
    input  logic                     in_valid,
    input  alu_op_t                  in_alu_op,
    input  src1_sel_t                in_src1_sel,
    input  src2_sel_t                in_src2_sel,
    input  logic                     in_word_op,
    input  logic                     in_rf_we,
    input  logic                     in_mem_re,
    input  logic                     in_mem_we,
    input  mem_size_t                in_mem_size,
    input  logic                     in_load_unsigned,
    input  logic [4:0]               in_rd,
    input  logic [11:0]              in_imm,
    input  logic [xlen-1:0]          in_rs1,
    input  logic [xlen-1:0]          in_rs2,
    input  logic [xlen-1:0]          in_pc,
    output logic                     in_allowin,
    // Memory stage side
    output logic                     es_to_ms_valid,
    input  logic                     ms_allowin,
    output ms_payload_t              es_to_ms_payload,
    output logic                     ram_en,
    output logic [xlen/8-1:0]        ram_be,
    output logic [ram_addr_bits-1:0] ram_addr,
    output logic [xlen-1:0]          ram_wdata
);

    es_payload_t       in_payload;
    es_payload_t       es;
    logic [xlen-1:0]   src1;
    logic [xlen-1:0]   src2;
    logic [xlen-1:0]   alu_result;
    logic [2:0]        addr_lo;
    logic [xlen/8-1:0] size_be;
    logic              es_go;

    always_comb begin
        in_payload.alu_op        = in_alu_op;
        in_payload.src1_sel      = in_src1_sel;
        in_payload.src2_sel      = in_src2_sel;
        in_payload.word_op       = in_word_op;
        in_payload.rf_we         = in_rf_we;
        in_payload.mem_re        = in_mem_re;
        in_payload.mem_we        = in_mem_we;
        in_payload.mem_size      = in_mem_size;
        in_payload.load_unsigned = in_load_unsigned;
        in_payload.rd            = in_rd;
        in_payload.imm           = in_imm;
        in_payload.rs1           = in_rs1;
        in_payload.rs2           = in_rs2;
        in_payload.pc            = in_pc;
    end

    pipe_stage #(
        .payload_t (es_payload_t)
    ) es_stage_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_payload  (in_payload),
        .allowin     (in_allowin),
        .out_valid   (es_to_ms_valid),
        .out_payload (es),
        .out_allowin (ms_allowin)
    );

    // ------------------------------------------------------------------------
    // Operand select and ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (es.src1_sel)
            src1_rs1: src1 = es.rs1;
            src1_pc:  src1 = es.pc;
            default:  src1 = '0;
        endcase
        case (es.src2_sel)
            src2_rs2:  src2 = es.rs2;
            src2_imm:  src2 = {{(xlen-12){es.imm[11]}}, es.imm};
            src2_four: src2 = xlen'(4);
            default:   src2 = '0;
        endcase
    end

    alu alu_i (
        .alu_op  (es.alu_op),
        .word_op (es.word_op),
        .src1    (src1),
        .src2    (src2),
        .result  (alu_result)
    );

    // ------------------------------------------------------------------------
    // Data RAM request, gated by the transfer into the memory stage
    // ------------------------------------------------------------------------
    assign addr_lo = alu_result[2:0];
    assign es_go   = es_to_ms_valid && ms_allowin;

    always_comb begin
        case (es.mem_size)
            size_b:  size_be = 8'h01;
            size_h:  size_be = 8'h03;
            size_w:  size_be = 8'h0f;
            default: size_be = 8'hff;
        endcase
    end

    assign ram_en    = es_go && (es.mem_re || es.mem_we);
    assign ram_be    = (es_go && es.mem_we) ? size_be << addr_lo : '0;
    assign ram_addr  = alu_result[ram_addr_bits+2:3];
    // Store data moved onto its byte lanes
    assign ram_wdata = es.rs2 << {addr_lo, 3'b000};

    always_comb begin
        es_to_ms_payload.rf_we         = es.rf_we;
        es_to_ms_payload.mem_re        = es.mem_re;
        es_to_ms_payload.mem_size      = es.mem_size;
        es_to_ms_payload.load_unsigned = es.load_unsigned;
        es_to_ms_payload.addr_lo       = addr_lo;
        es_to_ms_payload.rd            = es.rd;
        es_to_ms_payload.alu_result    = alu_result;
        es_to_ms_payload.pc            = es.pc;
    end

endmodule

//--- src/data_ram.sv
/*
 * Single-port data RAM, 2**ram_addr_bits words, byte write enables.
 * Read-first: rdata gets the old word; it holds while en is low.
 */
`timescale 1ns/1ps

module data_ram
    import rv_exec_pkg::*;
#(
    parameter int ram_addr_bits = 8
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic [xlen/8-1:0]        be,
    input  logic [ram_addr_bits-1:0] addr,
    input  logic [xlen-1:0]          wdata,
    output logic [xlen-1:0]          rdata
);

    logic [xlen-1:0] mem [2**ram_addr_bits];

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int i = 0; i < xlen/8; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- src/mem_stage.sv
/*
 * Memory stage: owns the data RAM, aligns and extends load data and
 * presents the writeback result until wb_ready takes it.
 */
`timescale 1ns/1ps

module mem_stage
    import rv_exec_pkg::*;
#(
    parameter int ram_addr_bits = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     es_to_ms_valid,
    input  ms_payload_t              es_to_ms_payload,
    input  logic                     ram_en,
    input  logic [xlen/8-1:0]        ram_be,
    input  logic [ram_addr_bits-1:0] ram_addr,
    input  logic [xlen-1:0]          ram_wdata,
    output logic                     ms_allowin,
    // Writeback
    output logic                     wb_valid,
    output logic                     wb_rf_we,
    output logic [4:0]               wb_rd,
    output logic [xlen-1:0]          wb_data,
    output logic [xlen-1:0]          wb_pc,
    input  logic                     wb_ready
);

    ms_payload_t     ms;
    logic [xlen-1:0] ram_rdata;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] load_data;

    pipe_stage #(
        .payload_t (ms_payload_t)
    ) ms_stage_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (es_to_ms_valid),
        .in_payload  (es_to_ms_payload),
        .allowin     (ms_allowin),
        .out_valid   (wb_valid),
        .out_payload (ms),
        .out_allowin (wb_ready)
    );

    data_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) data_ram_i (
        .clk   (clk),
        .en    (ram_en),
        .be    (ram_be),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // Bring the addressed bytes down to lane 0
    assign lane_data = ram_rdata >> {ms.addr_lo, 3'b000};

    always_comb begin
        case (ms.mem_size)
            size_b: begin
                load_data = {{(xlen-8){!ms.load_unsigned && lane_data[7]}}, lane_data[7:0]};
            end
            size_h: begin
                load_data = {{(xlen-16){!ms.load_unsigned && lane_data[15]}},
                             lane_data[15:0]};
            end
            size_w: begin
                load_data = {{(xlen-32){!ms.load_unsigned && lane_data[31]}},
                             lane_data[31:0]};
            end
            default: begin
                load_data = lane_data;
            end
        endcase
    end

    assign wb_rf_we = ms.rf_we;
    assign wb_rd    = ms.rd;
    assign wb_data  = ms.mem_re ? load_data : ms.alu_result;
    assign wb_pc    = ms.pc;

endmodule

//--- src/exec_mem_top.sv
/*
 * Execute and memory stages of an in-order RV64 integer pipe.
 * Two instructions in flight at most; results leave in order.
 */
`timescale 1ns/1ps

module exec_mem_top
    import rv_exec_pkg::*;
#(
    parameter int ram_addr_bits = 8
) (
    input  logic            clk,
    input  logic            reset,
    // Decode side
    input  logic            in_valid,
    input  alu_op_t         in_alu_op,
    input  src1_sel_t       in_src1_sel,
    input  src2_sel_t       in_src2_sel,
    input  logic            in_word_op,
    input  logic            in_rf_we,
    input  logic            in_mem_re,
    input  logic            in_mem_we,
    input  mem_size_t       in_mem_size,
    input  logic            in_load_unsigned,
    input  logic [4:0]      in_rd,
    input  logic [11:0]     in_imm,
    input  logic [xlen-1:0] in_rs1,
    input  logic [xlen-1:0] in_rs2,
    input  logic [xlen-1:0] in_pc,
    output logic            in_allowin,
    // Writeback side
    output logic            wb_valid,
    output logic            wb_rf_we,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data,
    output logic [xlen-1:0] wb_pc,
    input  logic            wb_ready
);

    logic                     es_to_ms_valid;
    ms_payload_t              es_to_ms_payload;
    logic                     ms_allowin;
    logic                     ram_en;
    logic [xlen/8-1:0]        ram_be;
    logic [ram_addr_bits-1:0] ram_addr;
    logic [xlen-1:0]          ram_wdata;

    exu #(
        .ram_addr_bits (ram_addr_bits)
    ) exu_i (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_alu_op        (in_alu_op),
        .in_src1_sel      (in_src1_sel),
        .in_src2_sel      (in_src2_sel),
        .in_word_op       (in_word_op),
        .in_rf_we         (in_rf_we),
        .in_mem_re        (in_mem_re),
        .in_mem_we        (in_mem_we),
        .in_mem_size      (in_mem_size),
        .in_load_unsigned (in_load_unsigned),
        .in_rd            (in_rd),
        .in_imm           (in_imm),
        .in_rs1           (in_rs1),
        .in_rs2           (in_rs2),
        .in_pc            (in_pc),
        .in_allowin       (in_allowin),
        .es_to_ms_valid   (es_to_ms_valid),
        .ms_allowin       (ms_allowin),
        .es_to_ms_payload (es_to_ms_payload),
        .ram_en           (ram_en),
        .ram_be           (ram_be),
        .ram_addr         (ram_addr),
        .ram_wdata        (ram_wdata)
    );

    mem_stage #(
        .ram_addr_bits (ram_addr_bits)
    ) mem_stage_i (
        .clk              (clk),
        .reset            (reset),
        .es_to_ms_valid   (es_to_ms_valid),
        .es_to_ms_payload (es_to_ms_payload),
        .ram_en           (ram_en),
        .ram_be           (ram_be),
        .ram_addr         (ram_addr),
        .ram_wdata        (ram_wdata),
        .ms_allowin       (ms_allowin),
        .wb_valid         (wb_valid),
        .wb_rf_we         (wb_rf_we),
        .wb_rd            (wb_rd),
        .wb_data          (wb_data),
        .wb_pc            (wb_pc),
        .wb_ready         (wb_ready)
    );

endmodule

//--- test/exec_mem_props.sv
/*
 * Handshake properties on the top level, bound into exec_mem_top.
 * Stalled means a writeback result is held while wb_ready is low.
 */
`timescale 1ns/1ps

module exec_mem_props
    import rv_exec_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic            wb_valid,
    input logic            wb_ready,
    input logic            wb_rf_we,
    input logic [4:0]      wb_rd,
    input logic [xlen-1:0] wb_data,
    input logic [xlen-1:0] wb_pc,
    input logic            ram_en
);

    int fail_count = 0;

    // Pipe is empty right after reset
    assert property (@(posedge clk) reset |=> !wb_valid)
        else begin
            $error("wb_valid high after reset");
            fail_count++;
        end

    // Writeback result holds under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_data) && $stable(wb_rd)
                                     && $stable(wb_rf_we) && $stable(wb_pc)))
        else begin
            $error("wb outputs changed while stalled");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset) (wb_valid && !wb_ready) |-> !ram_en)
        else begin
            $error("RAM access while memory stage stalled");
            fail_count++;
        end

endmodule

//--- test/exec_mem_checker.sv
/*
 * Watches accepted instructions and writeback transfers of the DUT.
 * Expected results come from exec_model and a byte model of the low
 * 2 KiB of data memory; loads only read bytes already stored.
 */
`timescale 1ns/1ps

module exec_mem_checker
    import rv_exec_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            check_latency,
    input  logic            in_valid,
    input  logic            in_allowin,
    input  alu_op_t         in_alu_op,
    input  src1_sel_t       in_src1_sel,
    input  src2_sel_t       in_src2_sel,
    input  logic            in_word_op,
    input  logic            in_rf_we,
    input  logic            in_mem_re,
    input  logic            in_mem_we,
    input  mem_size_t       in_mem_size,
    input  logic            in_load_unsigned,
    input  logic [4:0]      in_rd,
    input  logic [11:0]     in_imm,
    input  logic [xlen-1:0] in_rs1,
    input  logic [xlen-1:0] in_rs2,
    input  logic [xlen-1:0] in_pc,
    input  logic            wb_valid,
    input  logic            wb_ready,
    input  logic            wb_rf_we,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data,
    input  logic [xlen-1:0] wb_pc,
    output int              pass_count,
    output int              err_count,
    output int              pending
);

    typedef struct packed {
        logic            rf_we;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
        logic [xlen-1:0] pc;
        int              cycle;
    } expect_t;

    expect_t    exp_q[$];
    logic [7:0] model_mem [2048];
    int         n_pass = 0;
    int         n_err = 0;
    int         cycle = 0;
    logic       reset_q = 1'b1;

    // ------------------------------------------------------------------------
    // Reference model of one instruction, memory side effects included
    // ------------------------------------------------------------------------
    function automatic logic [63:0] exec_model(
        alu_op_t op, src1_sel_t s1, src2_sel_t s2, logic word, logic re, logic we,
        mem_size_t size, logic uns, logic [11:0] imm, logic [63:0] rs1,
        logic [63:0] rs2, logic [63:0] pc);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [63:0] ld;
        logic [10:0] addr;
        int          nbytes;
        a = (s1 == src1_rs1) ? rs1 : (s1 == src1_pc) ? pc : 64'd0;
        b = (s2 == src2_rs2) ? rs2 : (s2 == src2_imm) ? {{52{imm[11]}}, imm} :
            (s2 == src2_four) ? 64'd4 : 64'd0;
        case (op)
            alu_add:  r = a + b;
            alu_sub:  r = a - b;
            alu_slt:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            alu_sltu: r = (a < b) ? 64'd1 : 64'd0;
            alu_and:  r = a & b;
            alu_or:   r = a | b;
            alu_xor:  r = a ^ b;
            alu_sll:  r = word ? {32'd0, a[31:0] << b[4:0]} : a << b[5:0];
            alu_srl:  r = word ? {32'd0, a[31:0] >> b[4:0]} : a >> b[5:0];
            alu_sra: begin
                if (word) begin
                    r = {32'd0, $signed(a[31:0]) >>> b[4:0]};
                end else begin
                    r = $signed(a) >>> b[5:0];
                end
            end
            default:  r = 64'd0;
        endcase
        if (word) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        nbytes = 1 << int'(size);
        addr = r[10:0];
        if (we) begin
            for (int i = 0; i < nbytes; i++) begin
                model_mem[addr + 11'(i)] = rs2[8*i +: 8];
            end
        end
        if (re) begin
            ld = 64'd0;
            for (int i = 0; i < nbytes; i++) begin
                ld[8*i +: 8] = model_mem[addr + 11'(i)];
            end
            if (!uns && nbytes < 8 && ld[8*nbytes-1]) begin
                ld = ld | (~64'd0 << (8*nbytes));
            end
            r = ld;
        end
        return r;
    endfunction

    function automatic bit value_ok(string name, logic [63:0] expected, logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            n_err++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // In-order compare
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        expect_t e;
        if (reset) begin
            exp_q.delete();
            cycle = 0;
        end else begin
            cycle++;
            if (reset_q) begin
                if (value_ok("wb_valid", 64'(wb_valid), 64'd0)
                    & value_ok("in_allowin", 64'(in_allowin), 64'd1)) begin
                    n_pass++;
                end
            end
            if (check_latency && in_valid && !in_allowin) begin
                $display("Input stalled at %0d ns although wb_ready was high", $time);
                n_err++;
            end
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Result at %0d ns has no matching instruction", $time);
                    n_err++;
                end else begin
                    e = exp_q.pop_front();
                    if (value_ok("wb_data", e.data, wb_data)
                        & value_ok("wb_rd", 64'(e.rd), 64'(wb_rd))
                        & value_ok("wb_rf_we", 64'(e.rf_we), 64'(wb_rf_we))
                        & value_ok("wb_pc", e.pc, wb_pc)
                        & (!check_latency
                           || value_ok("latency", 64'(2), 64'(cycle - e.cycle)))) begin
                        n_pass++;
                    end
                end
            end
            if (in_valid && in_allowin) begin
                e.rf_we = in_rf_we;
                e.rd    = in_rd;
                e.pc    = in_pc;
                e.cycle = cycle;
                e.data  = exec_model(in_alu_op, in_src1_sel, in_src2_sel, in_word_op,
                                     in_mem_re, in_mem_we, in_mem_size, in_load_unsigned,
                                     in_imm, in_rs1, in_rs2, in_pc);
                exp_q.push_back(e);
            end
        end
        reset_q = reset;
        pass_count <= n_pass;
        err_count  <= n_err;
        pending    <= exp_q.size();
    end

endmodule

//--- test/exec_mem_tb.sv
/*
 * Testbench for exec_mem_top. Memory tests stay inside the low 256 bytes,
 * which are filled with double stores before any load.
 */
`timescale 1ns/1ps

module exec_mem_tb;
    import rv_exec_pkg::*;

    localparam int n_alu   = 200;
    localparam int n_word  = 64;
    localparam int n_mem   = 152;
    localparam int n_mix   = 200;
    localparam int n_lat   = 50;
    localparam int limit   = 4 * (n_alu + n_word + n_mem + n_mix + n_lat) + 100;

    logic            clk = 1'b0;
    logic            reset;
    logic            in_valid;
    alu_op_t         in_alu_op;
    src1_sel_t       in_src1_sel;
    src2_sel_t       in_src2_sel;
    logic            in_word_op;
    logic            in_rf_we;
    logic            in_mem_re;
    logic            in_mem_we;
    mem_size_t       in_mem_size;
    logic            in_load_unsigned;
    logic [4:0]      in_rd;
    logic [11:0]     in_imm;
    logic [xlen-1:0] in_rs1;
    logic [xlen-1:0] in_rs2;
    logic [xlen-1:0] in_pc;
    logic            in_allowin;
    logic            wb_valid;
    logic            wb_rf_we;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] wb_pc;
    logic            wb_ready;
    logic            check_latency;
    int              pass_count;
    int              err_count;
    int              pending;
    int              cycles = 0;
    int              pass_mark = 0;
    int              err_mark = 0;
    bit              random_ready = 1'b0;
    logic [63:0]     next_pc = 64'h1000;

    exec_mem_top #(.ram_addr_bits(8)) dut_i (.*);

    exec_mem_checker chk_i (.*);

    bind exec_mem_top exec_mem_props props_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        wb_ready <= random_ready ? 1'($urandom) : 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------
    task automatic send(alu_op_t op, src1_sel_t s1, src2_sel_t s2, logic word, logic rf_we,
                        logic re, logic we, mem_size_t size, logic uns, logic [11:0] imm,
                        logic [63:0] rs1, logic [63:0] rs2);
        in_valid         <= 1'b1;
        in_alu_op        <= op;
        in_src1_sel      <= s1;
        in_src2_sel      <= s2;
        in_word_op       <= word;
        in_rf_we         <= rf_we;
        in_mem_re        <= re;
        in_mem_we        <= we;
        in_mem_size      <= size;
        in_load_unsigned <= uns;
        in_imm           <= imm;
        in_rs1           <= rs1;
        in_rs2           <= rs2;
        in_rd            <= 5'($urandom);
        in_pc            <= next_pc;
        next_pc = next_pc + 64'd4;
        do @(posedge clk); while (!in_allowin);
    endtask

    task automatic send_random_alu(logic word);
        send(alu_op_t'(4'($urandom % 10)), src1_sel_t'(2'($urandom % 3)),
             src2_sel_t'(2'($urandom % 3)), word, 1'b1, 1'b0, 1'b0, size_d, 1'b0,
             12'($urandom), {$urandom, $urandom}, {$urandom, $urandom});
    endtask

    function automatic logic [63:0] aligned_addr(mem_size_t size);
        return {56'd0, 8'($urandom) & ~((8'd1 << size) - 8'd1)};
    endfunction

    task automatic send_store(mem_size_t size, logic [63:0] addr);
        send(alu_add, src1_rs1, src2_imm, 1'b0, 1'b0, 1'b0, 1'b1, size, 1'b0, 12'd0,
             addr, {$urandom, $urandom});
    endtask

    task automatic send_load(mem_size_t size, logic uns, logic [63:0] addr);
        send(alu_add, src1_rs1, src2_imm, 1'b0, 1'b1, 1'b1, 1'b0, size, uns, 12'd0,
             addr, 64'd0);
    endtask

    task automatic end_test(string name);
        in_valid <= 1'b0;
        @(posedge clk);
        while (pending != 0) @(posedge clk);
        @(posedge clk);
        $display("%-8s %0d passed, %0d errors", name, pass_count - pass_mark,
                 err_count - err_mark);
        pass_mark = pass_count;
        err_mark = err_count;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        alu_op_t   word_ops [4];
        int        amounts [4];
        mem_size_t size;
        word_ops = '{alu_add, alu_sll, alu_srl, alu_sra};
        amounts = '{0, 1, 31, 32};
        void'($urandom(431));
        reset = 1'b1;
        in_valid = 1'b0;
        in_alu_op = alu_add;
        in_src1_sel = src1_rs1;
        in_src2_sel = src2_rs2;
        in_word_op = 1'b0;
        in_rf_we = 1'b0;
        in_mem_re = 1'b0;
        in_mem_we = 1'b0;
        in_mem_size = size_b;
        in_load_unsigned = 1'b0;
        in_rd = 5'd0;
        in_imm = 12'd0;
        in_rs1 = 64'd0;
        in_rs2 = 64'd0;
        in_pc = 64'd0;
        wb_ready = 1'b1;
        check_latency = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        end_test("reset");

        repeat (n_alu) send_random_alu(1'b0);
        end_test("alu");

        // Shift amounts 31 and 32 with bit 31 of src1 set
        for (int r = 0; r < 4; r++) begin
            for (int o = 0; o < 4; o++) begin
                for (int s = 0; s < 4; s++) begin
                    send(word_ops[o], src1_rs1, src2_rs2, 1'b1, 1'b1, 1'b0, 1'b0, size_d,
                         1'b0, 12'd0, {$urandom, $urandom} | 64'h8000_0000,
                         64'(amounts[s]));
                end
            end
        end
        end_test("word");

        for (int w = 0; w < 32; w++) begin
            send_store(size_d, 64'(w * 8));
        end
        repeat (40) begin
            size = mem_size_t'(2'($urandom));
            send_store(size, aligned_addr(size));
        end
        repeat (80) begin
            size = mem_size_t'(2'($urandom));
            send_load(size, 1'($urandom), aligned_addr(size));
        end
        end_test("memory");

        random_ready = 1'b1;
        repeat (n_mix) begin
            size = mem_size_t'(2'($urandom));
            case ($urandom % 3)
                0: send_store(size, aligned_addr(size));
                1: send_load(size, 1'($urandom), aligned_addr(size));
                default: send_random_alu(1'($urandom));
            endcase
        end
        random_ready = 1'b0;
        end_test("stall");

        check_latency <= 1'b1;
        repeat (n_lat) begin
            size = mem_size_t'(2'($urandom));
            if ($urandom % 2 == 0) begin
                send_load(size, 1'($urandom), aligned_addr(size));
            end else begin
                send_random_alu(1'($urandom));
            end
        end
        end_test("latency");
        check_latency <= 1'b0;

        $display("Total: %0d passed, %0d errors, %0d assertion failures", pass_count,
                 err_count, dut_i.props_i.fail_count);
        if (err_count == 0 && dut_i.props_i.fail_count == 0 && pass_count > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- exec_mem_top.f
src/rv_exec_pkg.sv
src/pipe_stage.sv
src/alu.sv
src/exu.sv
src/data_ram.sv
src/mem_stage.sv
src/exec_mem_top.sv
test/exec_mem_props.sv
test/exec_mem_checker.sv
test/exec_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute/memory slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module exec_mem_tb -f exec_mem_top.f \
    -o exec_mem_sim || exit 1
result=$(./obj_dir/exec_mem_sim)
echo "$result"
echo "$result" | grep -q "^TEST PASSED$" && exit 0 || exit 1
